/* rayEngineInput.dat */
# P startX startY startZ dirX dirY dirZ lightX lightY lightZ pixelAddress
# R hit hitX hitY hitZ normalX normalY normalZ albedo reflect, one per trace in phase order
# E traceCount reflectDirX reflectDirY reflectDirZ fbWriteData
P 00000000 00000000 00000000 0000 0000 1000 0000 1000 0000 0010
R 0 00000000 00000000 00000000 0000 0000 0000 0000 00
E 1 0000 0000 0000 7e6a
P 00000000 00000000 00000000 0000 0000 1000 0000 1000 0000 0011
R 1 00000000 00000000 00050000 0000 1000 0000 2a52 00
R 0 00000000 00000000 00000000 0000 0000 0000 0000 00
E 2 0000 0000 0000 2a52
P 00000000 00000000 00000000 0000 0000 1000 0000 1000 0000 0012
R 1 00000000 00000000 00050000 0000 1000 0000 2a52 00
R 1 00000000 00000000 00000000 0000 0000 0000 0000 00
E 2 0000 0000 0000 1529
P 00000000 00000000 00000000 0000 0000 1000 0000 1000 0000 0013
R 1 00000000 00000000 00050000 0000 f000 0000 2a52 00
E 1 0000 0000 0000 1529
P 00000000 000a0000 00000000 0000 f000 0000 0000 1000 0000 0014
R 1 00000000 00000000 00000000 0000 1000 0000 7c00 80
R 0 00000000 00000000 00000000 0000 0000 0000 0000 00
R 1 00000000 00030000 00000000 0000 1000 0000 03e0 00
R 1 00000000 00000000 00000000 0000 0000 0000 0000 00
E 4 0000 1000 0000 3ce0
P 00000000 00000000 00000000 0000 1000 0000 0000 1000 0000 0015
R 1 00000000 00320000 00000000 0000 1000 0000 2a52 00
E 1 0000 0000 0000 2a52
P ffd70000 00000000 00000000 0000 0000 1000 0000 1000 0000 0016
E 0 0000 0000 0000 7e6a

/* rayEngine.f */
rayPkg.sv
secondaryRayCalc.sv
colourCalc.sv
phaseSequencer.sv
rayEngine.sv
rayEngineTb.sv

/* runSim.sh */
#!/bin/bash
# Build and run the ray engine regression with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module rayEngineTb -f rayEngine.f -o rayEngineSim \
	&& ./obj_dir/rayEngineSim | tee sim.log \
	|| echo "Build or simulation did not complete"
grep -q "Regression passed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* rayEngineTb.sv */
`timescale 1ns/1ps

module rayEngineTb;

	localparam int maxPixels = 16;
	localparam int maxResponses = 64;
	localparam int cyclesPerPixel = 200;

	logic clock;
	logic reset;
	logic startTick;
	logic busy;
	logic signed [rayPkg::posWidth-1:0] rayStartX, rayStartY, rayStartZ;
	logic signed [rayPkg::dirWidth-1:0] rayDirX, rayDirY, rayDirZ;
	logic signed [rayPkg::dirWidth-1:0] lightDirX, lightDirY, lightDirZ;
	logic [rayPkg::pixelAddrWidth-1:0] pixelAddress;
	logic traceStart;
	logic traceShadow;
	logic traceSecondary;
	logic signed [rayPkg::posWidth-1:0] traceRayStartX, traceRayStartY, traceRayStartZ;
	logic signed [rayPkg::dirWidth-1:0] traceRayDirX, traceRayDirY, traceRayDirZ;
	logic traceBusy;
	logic traceHit;
	logic signed [rayPkg::posWidth-1:0] traceHitX, traceHitY, traceHitZ;
	logic signed [rayPkg::dirWidth-1:0] traceNormalX, traceNormalY, traceNormalZ;
	logic [rayPkg::colourWidth-1:0] traceAlbedo;
	logic [rayPkg::reflectWidth-1:0] traceReflect;
	logic fbWriteOK;
	logic fbWrite;
	logic [rayPkg::pixelAddrWidth-1:0] fbWriteAddr;
	logic [rayPkg::colourWidth-1:0] fbWriteData;

	// Records from the data file
	logic [31:0] stim [maxPixels][10];
	logic [31:0] resp [maxResponses][9];
	logic [31:0] expected [maxPixels][5];
	int pixelCount = 0;
	int responseCount = 0;
	int respIdx = 0;

	int seed = 32'h1443f981;
	int busyCount = 0;
	int traceCount = 0;
	int writeCount = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycleLimit = 0;
	logic [15:0] seenDir [3];
	logic [31:0] seenStart [3];
	logic [31:0] primaryHitPos [3];
	logic reflectSeen = 1'b0;
	logic [1:0] phaseNow;
	logic [1:0] lastPhase = '0;
	logic [15:0] writtenData;
	logic [15:0] writtenAddr;
	logic [15:0] expAddr;
	logic [15:0] expData;
	logic okPrev = 1'b0;
	logic writePrev = 1'b0;
	logic [15:0] dataPrev = '0;
	logic [15:0] addrPrev = '0;

	rayEngine i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	// A 4.12 direction over 16 equals its raw value read as 16.16
	function automatic logic [31:0] biasedStart(input logic [31:0] hit,
		input logic [15:0] dir);
		return hit + {{16{dir[15]}}, dir};
	endfunction

	task automatic readStimulus();
		int fd;
		int n;
		int i;
		int want;
		string tag;
		string rest;
		logic [31:0] f [10];
		fd = $fopen("rayEngineInput.dat", "r");
		if (fd == 0) begin
			$display("Could not open rayEngineInput.dat");
			errors++;
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			want = 0;
			if (tag == "P" && pixelCount < maxPixels) begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
				want = 10;
				for (i = 0; i < 10; i++) stim[pixelCount][i] = f[i];
			end else if (tag == "R" && responseCount < maxResponses) begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				want = 9;
				for (i = 0; i < 9; i++) resp[responseCount][i] = f[i];
				responseCount++;
			end else if (tag == "E" && pixelCount < maxPixels) begin
				n = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
				want = 5;
				for (i = 0; i < 5; i++) expected[pixelCount][i] = f[i];
				pixelCount++;
			end else begin
				// Comment or unknown line
				n = $fgets(rest, fd);
			end
			if (want != 0 && n != want) begin
				$display("Line tagged %s in rayEngineInput.dat has too few fields", tag);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	task automatic runPixel(input int p);
		@(posedge clock);
		#2;
		rayStartX = stim[p][0];
		rayStartY = stim[p][1];
		rayStartZ = stim[p][2];
		rayDirX = stim[p][3][15:0];
		rayDirY = stim[p][4][15:0];
		rayDirZ = stim[p][5][15:0];
		lightDirX = stim[p][6][15:0];
		lightDirY = stim[p][7][15:0];
		lightDirZ = stim[p][8][15:0];
		pixelAddress = stim[p][9][15:0];
		expAddr = stim[p][9][15:0];
		expData = expected[p][4][15:0];
		traceCount = 0;
		writeCount = 0;
		seenDir[0] = '0;
		seenDir[1] = '0;
		seenDir[2] = '0;
		reflectSeen = 1'b0;
		startTick = 1'b1;
		@(posedge clock);
		#2;
		startTick = 1'b0;
		while (writeCount == 0 || busy) @(negedge clock);
		checkValue("traceCount", traceCount, expected[p][0]);
		checkValue("reflectDirX", seenDir[0], expected[p][1]);
		checkValue("reflectDirY", seenDir[1], expected[p][2]);
		checkValue("reflectDirZ", seenDir[2], expected[p][3]);
		// Reflection starts from the primary hit point
		if (reflectSeen) begin
			checkValue("reflectStartX", seenStart[0],
				biasedStart(primaryHitPos[0], expected[p][1][15:0]));
			checkValue("reflectStartY", seenStart[1],
				biasedStart(primaryHitPos[1], expected[p][2][15:0]));
			checkValue("reflectStartZ", seenStart[2],
				biasedStart(primaryHitPos[2], expected[p][3][15:0]));
		end
		checkValue("fbWrite count", writeCount, 1);
		checkValue("fbWriteAddr", writtenAddr, expAddr);
		checkValue("fbWriteData", writtenData, expData);
	endtask

	// Intersection engine and framebuffer models
	always @(posedge clock) begin
		#2;
		fbWriteOK = ($random(seed) & 3) != 0;
		if (busyCount > 0) busyCount--;
		if (traceStart) begin
			// Phase number is secondary then shadow, and phases only move forward
			phaseNow = {traceSecondary, traceShadow};
			if (traceCount == 0) begin
				checkValue("first trace phase", phaseNow, rayPkg::primaryRay);
			end else if (phaseNow <= lastPhase) begin
				$display("Trace phase %0d at %0t ns does not follow phase %0d",
					phaseNow, $time, lastPhase);
				errors++;
			end
			lastPhase = phaseNow;
			traceCount++;
			// Shadow rays point at the light
			if (traceShadow) begin
				checkValue("shadow traceRayDirX", traceRayDirX, lightDirX);
				checkValue("shadow traceRayDirY", traceRayDirY, lightDirY);
				checkValue("shadow traceRayDirZ", traceRayDirZ, lightDirZ);
			end
			if (traceSecondary && !traceShadow) begin
				seenDir[0] = traceRayDirX;
				seenDir[1] = traceRayDirY;
				seenDir[2] = traceRayDirZ;
				seenStart[0] = traceRayStartX;
				seenStart[1] = traceRayStartY;
				seenStart[2] = traceRayStartZ;
				reflectSeen = 1'b1;
			end
			if (respIdx < responseCount) begin
				traceHit = resp[respIdx][0][0];
				traceHitX = resp[respIdx][1];
				traceHitY = resp[respIdx][2];
				traceHitZ = resp[respIdx][3];
				traceNormalX = resp[respIdx][4][15:0];
				traceNormalY = resp[respIdx][5][15:0];
				traceNormalZ = resp[respIdx][6][15:0];
				traceAlbedo = resp[respIdx][7][15:0];
				traceReflect = resp[respIdx][8][7:0];
				if (phaseNow == rayPkg::primaryRay) begin
					primaryHitPos[0] = resp[respIdx][1];
					primaryHitPos[1] = resp[respIdx][2];
					primaryHitPos[2] = resp[respIdx][3];
				end
			end else begin
				$display("Trace request at %0t ns has no response left in the data file", $time);
				errors++;
				traceHit = 1'b0;
			end
			respIdx++;
			busyCount = 1 + ($unsigned($random(seed)) % 8);
		end
		traceBusy = busyCount > 0;
	end

	// Framebuffer protocol watch, sampled mid-cycle
	always @(negedge clock) begin
		if (!reset) begin
			if (fbWrite) begin
				writeCount++;
				writtenData = fbWriteData;
				writtenAddr = fbWriteAddr;
				if (!okPrev) begin
					$display("fbWrite pulsed at %0t ns without fbWriteOK", $time);
					errors++;
				end
			end
			if (writePrev && busy) begin
				$display("busy still high at %0t ns after the fbWrite pulse", $time);
				errors++;
			end
			if (busy && dataPrev == expData && addrPrev == expAddr &&
				(fbWriteData != dataPrev || fbWriteAddr != addrPrev)) begin
				$display("Framebuffer address or data changed at %0t ns before the write", $time);
				errors++;
			end
			okPrev = fbWriteOK;
			writePrev = fbWrite;
			dataPrev = fbWriteData;
			addrPrev = fbWriteAddr;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("Timeout after %0d cycles with the DUT still busy", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		startTick = 1'b0;
		rayStartX = '0;
		rayStartY = '0;
		rayStartZ = '0;
		rayDirX = '0;
		rayDirY = '0;
		rayDirZ = '0;
		lightDirX = '0;
		lightDirY = '0;
		lightDirZ = '0;
		pixelAddress = '0;
		traceBusy = 1'b0;
		traceHit = 1'b0;
		traceHitX = '0;
		traceHitY = '0;
		traceHitZ = '0;
		traceNormalX = '0;
		traceNormalY = '0;
		traceNormalZ = '0;
		traceAlbedo = '0;
		traceReflect = '0;
		fbWriteOK = 1'b0;
		expAddr = '0;
		expData = '0;
		readStimulus();
		cycleLimit = cyclesPerPixel * pixelCount + 20;
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		for (int p = 0; p < pixelCount; p++) runPixel(p);
		$display("Pixels: %0d, checks: %0d, errors: %0d", pixelCount, checks, errors);
		if (errors == 0 && pixelCount > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* rayEngine.sv */
`timescale 1ns/1ps

module rayEngine (
	input logic clock,
	input logic reset,

	// Host
	input logic startTick,
	output logic busy,
	input logic signed [rayPkg::posWidth-1:0] rayStartX, rayStartY, rayStartZ,
	input logic signed [rayPkg::dirWidth-1:0] rayDirX, rayDirY, rayDirZ,
	input logic signed [rayPkg::dirWidth-1:0] lightDirX, lightDirY, lightDirZ,
	input logic [rayPkg::pixelAddrWidth-1:0] pixelAddress,

	// Intersection engine
	output logic traceStart,
	output logic traceShadow,
	output logic traceSecondary,
	output logic signed [rayPkg::posWidth-1:0] traceRayStartX, traceRayStartY, traceRayStartZ,
	output logic signed [rayPkg::dirWidth-1:0] traceRayDirX, traceRayDirY, traceRayDirZ,
	input logic traceBusy,
	input logic traceHit,
	input logic signed [rayPkg::posWidth-1:0] traceHitX, traceHitY, traceHitZ,
	input logic signed [rayPkg::dirWidth-1:0] traceNormalX, traceNormalY, traceNormalZ,
	input logic [rayPkg::colourWidth-1:0] traceAlbedo,
	input logic [rayPkg::reflectWidth-1:0] traceReflect,

	// Framebuffer
	input logic fbWriteOK,
	output logic fbWrite,
	output logic [rayPkg::pixelAddrWidth-1:0] fbWriteAddr,
	output logic [rayPkg::colourWidth-1:0] fbWriteData
);

	// Current hit record toward the secondary ray calculator
	logic signed [rayPkg::posWidth-1:0] hitX, hitY, hitZ;
	logic signed [rayPkg::dirWidth-1:0] hitNormalX, hitNormalY, hitNormalZ;
	logic signed [rayPkg::dirWidth-1:0] currentDirX, currentDirY, currentDirZ;
	logic signed [rayPkg::dirWidth-1:0] lightX, lightY, lightZ;

	// Derived rays
	logic signed [rayPkg::posWidth-1:0] shadowStartX, shadowStartY, shadowStartZ;
	logic signed [rayPkg::dirWidth-1:0] shadowDirX, shadowDirY, shadowDirZ;
	logic signed [rayPkg::posWidth-1:0] reflectStartX, reflectStartY, reflectStartZ;
	logic signed [rayPkg::dirWidth-1:0] reflectDirX, reflectDirY, reflectDirZ;
	logic signed [rayPkg::dirWidth-1:0] normalDotLight;

	// Hit summary for shading
	logic primaryHit;
	logic primaryShadowed;
	logic [rayPkg::colourWidth-1:0] primaryAlbedo;
	logic [rayPkg::reflectWidth-1:0] primaryReflect;
	logic secondaryHit;
	logic secondaryShadowed;
	logic [rayPkg::colourWidth-1:0] secondaryAlbedo;
	logic [rayPkg::colourWidth-1:0] pixelColour;

	phaseSequencer i_phaseSequencer (.*);

	secondaryRayCalc i_secondaryRayCalc (.*);

	colourCalc i_colourCalc (.*);

endmodule

/* phaseSequencer.sv */
`timescale 1ns/1ps

module phaseSequencer (
	input logic clock,
	input logic reset,

	input logic startTick,
	output logic busy,
	input logic signed [rayPkg::posWidth-1:0] rayStartX, rayStartY, rayStartZ,
	input logic signed [rayPkg::dirWidth-1:0] rayDirX, rayDirY, rayDirZ,
	input logic signed [rayPkg::dirWidth-1:0] lightDirX, lightDirY, lightDirZ,
	input logic [rayPkg::pixelAddrWidth-1:0] pixelAddress,

	output logic traceStart,
	output logic traceShadow,
	output logic traceSecondary,
	output logic signed [rayPkg::posWidth-1:0] traceRayStartX, traceRayStartY, traceRayStartZ,
	output logic signed [rayPkg::dirWidth-1:0] traceRayDirX, traceRayDirY, traceRayDirZ,
	input logic traceBusy,
	input logic traceHit,
	input logic signed [rayPkg::posWidth-1:0] traceHitX, traceHitY, traceHitZ,
	input logic signed [rayPkg::dirWidth-1:0] traceNormalX, traceNormalY, traceNormalZ,
	input logic [rayPkg::colourWidth-1:0] traceAlbedo,
	input logic [rayPkg::reflectWidth-1:0] traceReflect,

	input logic fbWriteOK,
	output logic fbWrite,
	output logic [rayPkg::pixelAddrWidth-1:0] fbWriteAddr,
	output logic [rayPkg::colourWidth-1:0] fbWriteData,

	output logic signed [rayPkg::posWidth-1:0] hitX, hitY, hitZ,
	output logic signed [rayPkg::dirWidth-1:0] hitNormalX, hitNormalY, hitNormalZ,
	output logic signed [rayPkg::dirWidth-1:0] currentDirX, currentDirY, currentDirZ,
	output logic signed [rayPkg::dirWidth-1:0] lightX, lightY, lightZ,
	input logic signed [rayPkg::posWidth-1:0] shadowStartX, shadowStartY, shadowStartZ,
	input logic signed [rayPkg::dirWidth-1:0] shadowDirX, shadowDirY, shadowDirZ,
	input logic signed [rayPkg::posWidth-1:0] reflectStartX, reflectStartY, reflectStartZ,
	input logic signed [rayPkg::dirWidth-1:0] reflectDirX, reflectDirY, reflectDirZ,
	input logic signed [rayPkg::dirWidth-1:0] normalDotLight,

	output logic primaryHit,
	output logic primaryShadowed,
	output logic [rayPkg::colourWidth-1:0] primaryAlbedo,
	output logic [rayPkg::reflectWidth-1:0] primaryReflect,
	output logic secondaryHit,
	output logic secondaryShadowed,
	output logic [rayPkg::colourWidth-1:0] secondaryAlbedo,
	input logic [rayPkg::colourWidth-1:0] pixelColour
);

	typedef enum logic [2:0] {
		idle,
		startPhase,
		traceLaunch,
		traceWait,
		finishPhase,
		writeSetup,
		writeWait
	} seqState;

	seqState state;
	rayPkg::tracePhase phase;
	rayPkg::tracePhase nextPhase;
	logic runNext;
	logic markShadowed;
	logic isPrimary;
	logic startInBounds;

	// Hit record storage beyond what shading needs
	logic signed [rayPkg::posWidth-1:0] primHitX, primHitY, primHitZ;
	logic signed [rayPkg::posWidth-1:0] secHitX, secHitY, secHitZ;
	logic signed [rayPkg::dirWidth-1:0] primNormalX, primNormalY, primNormalZ;
	logic signed [rayPkg::dirWidth-1:0] secNormalX, secNormalY, secNormalZ;
	logic signed [rayPkg::dirWidth-1:0] primDirX, primDirY, primDirZ;

	function automatic logic inRange(input logic signed [rayPkg::posWidth-1:0] v);
		return (v >= rayPkg::minTraceStart) && (v <= rayPkg::maxTraceStart);
	endfunction

	assign startInBounds = inRange(traceRayStartX) && inRange(traceRayStartY) &&
		inRange(traceRayStartZ);

	assign isPrimary = (phase == rayPkg::primaryRay) || (phase == rayPkg::primaryShadow);
	assign traceShadow = (phase == rayPkg::primaryShadow) || (phase == rayPkg::secondaryShadow);
	assign traceSecondary = !isPrimary;

	// Neighbours always see the record belonging to the current phase
	assign hitX = isPrimary ? primHitX : secHitX;
	assign hitY = isPrimary ? primHitY : secHitY;
	assign hitZ = isPrimary ? primHitZ : secHitZ;
	assign hitNormalX = isPrimary ? primNormalX : secNormalX;
	assign hitNormalY = isPrimary ? primNormalY : secNormalY;
	assign hitNormalZ = isPrimary ? primNormalZ : secNormalZ;
	assign currentDirX = isPrimary ? primDirX : traceRayDirX;
	assign currentDirY = isPrimary ? primDirY : traceRayDirY;
	assign currentDirZ = isPrimary ? primDirZ : traceRayDirZ;

	// Which phase follows the one just finished
	always_comb begin
		runNext = 1'b0;
		nextPhase = phase;
		markShadowed = 1'b0;
		case (phase)
			rayPkg::primaryRay: begin
				if (primaryHit) begin
					if (normalDotLight > 0) begin
						runNext = 1'b1;
						nextPhase = rayPkg::primaryShadow;
					end else begin
						// Facing away from the light, so assume shadowed
						markShadowed = 1'b1;
						if (primaryReflect != '0) begin
							runNext = 1'b1;
							nextPhase = rayPkg::secondaryRay;
						end
					end
				end
			end
			rayPkg::primaryShadow: begin
				if (primaryReflect != '0) begin
					runNext = 1'b1;
					nextPhase = rayPkg::secondaryRay;
				end
			end
			rayPkg::secondaryRay: begin
				if (secondaryHit) begin
					if (normalDotLight > 0) begin
						runNext = 1'b1;
						nextPhase = rayPkg::secondaryShadow;
					end else begin
						markShadowed = 1'b1;
					end
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= idle;
			phase <= rayPkg::primaryRay;
			busy <= 1'b0;
			traceStart <= 1'b0;
			fbWrite <= 1'b0;
		end else begin
			traceStart <= 1'b0;
			fbWrite <= 1'b0;
			case (state)
				idle: begin
					busy <= startTick;
					if (startTick) begin
						phase <= rayPkg::primaryRay;
						state <= startPhase;
					end
				end
				startPhase: begin
					// Out of bounds start is a miss without tracing
					if (startInBounds) begin
						traceStart <= 1'b1;
						state <= traceLaunch;
					end else begin
						state <= finishPhase;
					end
				end
				// Engine busy is not valid yet
				traceLaunch: state <= traceWait;
				traceWait: begin
					if (!traceBusy) begin
						state <= finishPhase;
					end
				end
				finishPhase: begin
					if (runNext) begin
						phase <= nextPhase;
						state <= startPhase;
					end else begin
						state <= writeSetup;
					end
				end
				writeSetup: state <= writeWait;
				writeWait: begin
					if (fbWriteOK) begin
						fbWrite <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			idle: begin
				if (startTick) begin
					traceRayStartX <= rayStartX;
					traceRayStartY <= rayStartY;
					traceRayStartZ <= rayStartZ;
					traceRayDirX <= rayDirX;
					traceRayDirY <= rayDirY;
					traceRayDirZ <= rayDirZ;
					primDirX <= rayDirX;
					primDirY <= rayDirY;
					primDirZ <= rayDirZ;
					lightX <= lightDirX;
					lightY <= lightDirY;
					lightZ <= lightDirZ;
					fbWriteAddr <= pixelAddress;
					// Cleared flags double as the skipped-phase result
					primaryHit <= 1'b0;
					primaryShadowed <= 1'b0;
					secondaryHit <= 1'b0;
					secondaryShadowed <= 1'b0;
				end
			end
			traceWait: begin
				if (!traceBusy) begin
					case (phase)
						rayPkg::primaryRay: begin
							primaryHit <= traceHit;
							primHitX <= traceHitX;
							primHitY <= traceHitY;
							primHitZ <= traceHitZ;
							primNormalX <= traceNormalX;
							primNormalY <= traceNormalY;
							primNormalZ <= traceNormalZ;
							primaryAlbedo <= traceAlbedo;
							primaryReflect <= traceReflect;
						end
						rayPkg::primaryShadow: primaryShadowed <= traceHit;
						rayPkg::secondaryRay: begin
							secondaryHit <= traceHit;
							secHitX <= traceHitX;
							secHitY <= traceHitY;
							secHitZ <= traceHitZ;
							secNormalX <= traceNormalX;
							secNormalY <= traceNormalY;
							secNormalZ <= traceNormalZ;
							secondaryAlbedo <= traceAlbedo;
						end
						default: secondaryShadowed <= traceHit;
					endcase
				end
			end
			finishPhase: begin
				if (markShadowed && isPrimary) begin
					primaryShadowed <= 1'b1;
				end
				if (markShadowed && !isPrimary) begin
					secondaryShadowed <= 1'b1;
				end
				if (runNext && nextPhase == rayPkg::secondaryRay) begin
					traceRayStartX <= reflectStartX;
					traceRayStartY <= reflectStartY;
					traceRayStartZ <= reflectStartZ;
					traceRayDirX <= reflectDirX;
					traceRayDirY <= reflectDirY;
					traceRayDirZ <= reflectDirZ;
				end else if (runNext) begin
					traceRayStartX <= shadowStartX;
					traceRayStartY <= shadowStartY;
					traceRayStartZ <= shadowStartZ;
					traceRayDirX <= shadowDirX;
					traceRayDirY <= shadowDirY;
					traceRayDirZ <= shadowDirZ;
				end
			end
			writeSetup: fbWriteData <= pixelColour;
			default: begin
			end
		endcase
	end

endmodule

/* colourCalc.sv */
`timescale 1ns/1ps

module colourCalc (
	input logic primaryHit,
	input logic primaryShadowed,
	input logic [rayPkg::colourWidth-1:0] primaryAlbedo,
	input logic [rayPkg::reflectWidth-1:0] primaryReflect,
	input logic secondaryHit,
	input logic secondaryShadowed,
	input logic [rayPkg::colourWidth-1:0] secondaryAlbedo,
	output logic [rayPkg::colourWidth-1:0] pixelColour
);

	logic [14:0] primaryColour;
	logic [14:0] secondaryColour;
	logic [14:0] blended;
	logic useBlend;

	// Sky on a miss, albedo on a hit, half brightness in shadow
	function automatic logic [14:0] phaseColour(
		input logic hit,
		input logic shadowed,
		input logic [rayPkg::colourWidth-1:0] albedo
	);
		if (!hit) begin
			return rayPkg::skyColour[14:0];
		end
		if (shadowed) begin
			return {1'b0, albedo[14:11], 1'b0, albedo[9:6], 1'b0, albedo[4:1]};
		end
		return albedo[14:0];
	endfunction

	function automatic logic [4:0] blendChannel(
		input logic [4:0] p,
		input logic [4:0] s,
		input logic [rayPkg::reflectWidth-1:0] r
	);
		logic [13:0] mix;
		mix = 14'(p) * (14'(1 << rayPkg::reflectWidth) - 14'(r)) + 14'(s) * 14'(r);
		return mix[12:8];
	endfunction

	assign primaryColour = phaseColour(primaryHit, primaryShadowed, primaryAlbedo);
	assign secondaryColour = phaseColour(secondaryHit, secondaryShadowed, secondaryAlbedo);

	// Channels are blue, green, red from the top
	assign blended = {
		blendChannel(primaryColour[14:10], secondaryColour[14:10], primaryReflect),
		blendChannel(primaryColour[9:5], secondaryColour[9:5], primaryReflect),
		blendChannel(primaryColour[4:0], secondaryColour[4:0], primaryReflect)
	};

	// Only a reflective primary hit mixes in the secondary colour
	assign useBlend = primaryHit && (primaryReflect != '0);
	assign pixelColour = {1'b0, useBlend ? blended : primaryColour};

endmodule

/* secondaryRayCalc.sv */
`timescale 1ns/1ps

module secondaryRayCalc (
	input logic signed [rayPkg::posWidth-1:0] hitX, hitY, hitZ,
	input logic signed [rayPkg::dirWidth-1:0] hitNormalX, hitNormalY, hitNormalZ,
	input logic signed [rayPkg::dirWidth-1:0] currentDirX, currentDirY, currentDirZ,
	input logic signed [rayPkg::dirWidth-1:0] lightX, lightY, lightZ,
	output logic signed [rayPkg::posWidth-1:0] shadowStartX, shadowStartY, shadowStartZ,
	output logic signed [rayPkg::dirWidth-1:0] shadowDirX, shadowDirY, shadowDirZ,
	output logic signed [rayPkg::posWidth-1:0] reflectStartX, reflectStartY, reflectStartZ,
	output logic signed [rayPkg::dirWidth-1:0] reflectDirX, reflectDirY, reflectDirZ,
	output logic signed [rayPkg::dirWidth-1:0] normalDotLight
);

	localparam int prodWidth = 2 * rayPkg::dirWidth;

	logic signed [prodWidth-1:0] normalDotDir;
	logic signed [prodWidth-1:0] normalDotLightFull;

	function automatic logic signed [prodWidth-1:0] fixMul(
		input logic signed [rayPkg::dirWidth-1:0] a,
		input logic signed [rayPkg::dirWidth-1:0] b
	);
		logic signed [prodWidth-1:0] product;
		product = a * b;
		return product >>> rayPkg::dirFracBits;
	endfunction

	// d - 2 (n.d) n, per component
	function automatic logic signed [rayPkg::dirWidth-1:0] reflectComp(
		input logic signed [rayPkg::dirWidth-1:0] d,
		input logic signed [rayPkg::dirWidth-1:0] n,
		input logic signed [prodWidth-1:0] dot
	);
		logic signed [prodWidth-1:0] scaled;
		scaled = fixMul(dot[rayPkg::dirWidth-1:0], n) <<< 1;
		return d - scaled[rayPkg::dirWidth-1:0];
	endfunction

	// Hit point nudged a fraction of the way along the new ray
	function automatic logic signed [rayPkg::posWidth-1:0] biasStart(
		input logic signed [rayPkg::posWidth-1:0] hit,
		input logic signed [rayPkg::dirWidth-1:0] dir
	);
		logic signed [rayPkg::posWidth-1:0] dirPos;
		dirPos = {{(rayPkg::posWidth - rayPkg::dirWidth){dir[rayPkg::dirWidth-1]}}, dir};
		dirPos = dirPos <<< (rayPkg::posFracBits - rayPkg::dirFracBits);
		return hit + (dirPos >>> rayPkg::biasShift);
	endfunction

	assign normalDotLightFull = fixMul(hitNormalX, lightX) + fixMul(hitNormalY, lightY) +
		fixMul(hitNormalZ, lightZ);
	assign normalDotLight = normalDotLightFull[rayPkg::dirWidth-1:0];

	assign normalDotDir = fixMul(hitNormalX, currentDirX) + fixMul(hitNormalY, currentDirY) +
		fixMul(hitNormalZ, currentDirZ);

	// Shadow rays head straight for the light
	assign shadowDirX = lightX;
	assign shadowDirY = lightY;
	assign shadowDirZ = lightZ;
	assign shadowStartX = biasStart(hitX, shadowDirX);
	assign shadowStartY = biasStart(hitY, shadowDirY);
	assign shadowStartZ = biasStart(hitZ, shadowDirZ);

	assign reflectDirX = reflectComp(currentDirX, hitNormalX, normalDotDir);
	assign reflectDirY = reflectComp(currentDirY, hitNormalY, normalDotDir);
	assign reflectDirZ = reflectComp(currentDirZ, hitNormalZ, normalDotDir);
	assign reflectStartX = biasStart(hitX, reflectDirX);
	assign reflectStartY = biasStart(hitY, reflectDirY);
	assign reflectStartZ = biasStart(hitZ, reflectDirZ);

endmodule

/* rayPkg.sv */
package rayPkg;

	// Position coordinates, signed 16.16 fixed point
	localparam int posWidth = 32;
	localparam int posFracBits = 16;

	// Directions and normals, signed 4.12 fixed point
	localparam int dirWidth = 16;
	localparam int dirFracBits = 12;

	// Ray starts outside [-40.0, +50.0] on any axis never hit anything
	localparam logic signed [posWidth-1:0] minTraceStart = 32'shFFD8_0000;
	localparam logic signed [posWidth-1:0] maxTraceStart = 32'sh0032_0000;

	// Secondary ray starts are pushed along the ray by dir / 16
	localparam int biasShift = 4;

	localparam int pixelAddrWidth = 16;

	// 1:5:5:5 with zero top bit, then blue, green, red
	localparam int colourWidth = 16;

	// Reflectiveness in 1/256 units
	localparam int reflectWidth = 8;

	// Colour of a ray that leaves the scene
	localparam logic [colourWidth-1:0] skyColour = 16'h7E6A;

	// Tracing phases, run in this order
	typedef enum logic [1:0] {
		primaryRay,
		primaryShadow,
		secondaryRay,
		secondaryShadow
	} tracePhase;

endpackage
